// File: include/clk_params.svh
/*
 * Clock board diagnostic widths and counts
 */
`ifndef CLK_PARAMS_SVH
`define CLK_PARAMS_SVH

// Function select and status word select
`define CLK_SEL_W 3
// One load data nibble
`define CLK_DATA_W 4
// Diagnostic status word
`define CLK_DIAG_W 6
`define CLK_BURST_W 8
// Rate select and source select fields
`define CLK_RATE_W 2
// EBOX section disables (CRM, EDP, CTL)
`define CLK_DIS_W 3
// Free running divider, covers the slowest rate of 1 in 8
`define CLK_DIV_W 3

`endif

// File: verilog/clkPkg.sv
/*
 * Clock board types
 * Diagnostic function groups and the control and load function codes
 */
`include "clk_params.svh"

package clkPkg;

  typedef enum logic [1:0] {
    ctlFunc  = 2'd0,  // 00x control functions
    ldFunc   = 2'd1,  // 04x load functions
    readFunc = 2'd2   // Status word read
  } funcGroup_t;

  typedef enum logic [`CLK_SEL_W-1:0] {
    none       = 3'd0,
    start      = 3'd1,
    singleStep = 3'd2,
    eboxSS     = 3'd3,
    condSS     = 3'd4,  // Acts as a stop here
    burst      = 3'd5,
    clrReset   = 3'd6,
    setReset   = 3'd7
  } ctlFunc_t;

  typedef enum logic [`CLK_SEL_W-1:0] {
    ldNone0 = 3'd0,
    ldNone1 = 3'd1,
    burstLo = 3'd2,
    burstHi = 3'd3,
    rateSel = 3'd4,  // Source select and rate select together
    ebosDis = 3'd5,
    parChk  = 3'd6,
    misc    = 3'd7
  } ldFunc_t;

endpackage

// File: verilog/diagFuncPort.sv
/*
 * Diagnostic function port
 * Four-phase req/ack handshake, decodes the accepted function into
 * one strobe and captures the status word on reads
 */
`include "clk_params.svh"

module diagFuncPort (
  input  logic                    CLK,
  input  logic                    FPGA_RESET,
  input  logic                    funcReq,
  input  clkPkg::funcGroup_t      funcGroup,
  input  logic [`CLK_SEL_W-1:0]   funcSel,
  input  logic [`CLK_DATA_W-1:0]  funcData,
  input  logic [`CLK_DIAG_W-1:0]  statusWord,
  output logic                    funcAck,
  output logic [`CLK_DIAG_W-1:0]  readData,
  output logic                    ctlStrobe,
  output clkPkg::ctlFunc_t        ctlCode,
  output logic                    ldStrobe,
  output clkPkg::ldFunc_t         ldCode,
  output logic [`CLK_DATA_W-1:0]  ldData,
  output logic [`CLK_SEL_W-1:0]   wordSel
);

  logic accept;

  // New request seen while the previous ack has dropped
  assign accept = funcReq & ~funcAck;

  // Status mux follows the select for the whole request
  assign wordSel = funcSel;

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      funcAck   <= 1'b0;
      ctlStrobe <= 1'b0;
      ldStrobe  <= 1'b0;
      readData  <= '0;
    end else begin
      ctlStrobe <= accept && (funcGroup == clkPkg::ctlFunc);
      ldStrobe  <= accept && (funcGroup == clkPkg::ldFunc);
      if (accept) begin
        funcAck <= 1'b1;
      end else if (!funcReq) begin
        funcAck <= 1'b0;  // Host released req
      end
      if (accept && (funcGroup == clkPkg::readFunc)) begin
        readData <= statusWord;
      end
    end
  end

  // Codes and data travel with the strobes
  always_ff @(posedge CLK) begin
    if (accept) begin
      ctlCode <= clkPkg::ctlFunc_t'(funcSel);
      ldCode  <= clkPkg::ldFunc_t'(funcSel);
      ldData  <= funcData;
    end
  end

endmodule

// File: verilog/clkConfigRegs.sv
/*
 * Load function configuration registers 044 to 047
 */
`include "clk_params.svh"

module clkConfigRegs (
  input  logic                    CLK,
  input  logic                    FPGA_RESET,
  input  logic                    ldStrobe,
  input  clkPkg::ldFunc_t         ldCode,
  input  logic [`CLK_DATA_W-1:0]  ldData,
  output logic [`CLK_RATE_W-1:0]  sourceSel,
  output logic [`CLK_RATE_W-1:0]  rateSel,
  output logic [`CLK_DIS_W-1:0]   ebosDis,
  output logic [`CLK_DATA_W-1:0]  parChk,
  output logic [`CLK_DATA_W-1:0]  miscEn
);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      sourceSel <= '0;
      rateSel   <= '0;  // One tick per cycle
      ebosDis   <= '0;
      parChk    <= '0;
      miscEn    <= '0;
    end else if (ldStrobe) begin
      case (ldCode)
        clkPkg::rateSel: begin
          sourceSel <= ldData[3:2];
          rateSel   <= ldData[1:0];
        end
        // CRM, EDP, CTL from high to low
        clkPkg::ebosDis: ebosDis <= ldData[`CLK_DIS_W-1:0];
        clkPkg::parChk:  parChk  <= ldData;
        clkPkg::misc:    miscEn  <= ldData;
        default: begin
          // Burst count codes go to the counter
        end
      endcase
    end
  end

endmodule

// File: verilog/burstCounter.sv
/*
 * Burst counter
 * Loaded a nibble at a time, counts down one per burst tick
 */
`include "clk_params.svh"

module burstCounter (
  input  logic                    CLK,
  input  logic                    FPGA_RESET,
  input  logic                    ldStrobe,
  input  clkPkg::ldFunc_t         ldCode,
  input  logic [`CLK_DATA_W-1:0]  ldData,
  input  logic                    burstStep,
  output logic [`CLK_BURST_W-1:0] burstCount,
  output logic                    burstZero
);

  assign burstZero = (burstCount == '0);

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      burstCount <= '0;
    end else if (ldStrobe && (ldCode == clkPkg::burstLo)) begin
      burstCount[3:0] <= ldData;
    end else if (ldStrobe && (ldCode == clkPkg::burstHi)) begin
      burstCount[7:4] <= ldData;
    end else if (burstStep) begin
      burstCount <= burstCount - 1'b1;  // Never stepped at zero
    end
  end

endmodule

// File: verilog/clockGate.sv
/*
 * EBOX clock gate
 * Run modes, rate divider, gated clock enable and master reset flag
 */
`include "clk_params.svh"

module clockGate (
  input  logic                    CLK,
  input  logic                    FPGA_RESET,
  input  logic                    ctlStrobe,
  input  clkPkg::ctlFunc_t        ctlCode,
  input  logic [`CLK_RATE_W-1:0]  rateSel,
  input  logic                    burstZero,
  output logic                    runEnable,
  output logic                    burstStep,
  output logic                    goMode,
  output logic                    burstMode,
  output logic                    eboxSS,
  output logic                    mrReset
);

  logic [`CLK_DIV_W-1:0] rateCnt;
  logic [`CLK_DIV_W-1:0] rateMask;
  logic                  rateTick;
  logic                  stepPend;

  // 2^rateSel - 1, low bits that must all be set for a tick
  assign rateMask = (`CLK_DIV_W'(1) << rateSel) - 1'b1;
  assign rateTick = ((rateCnt & rateMask) == rateMask);

  assign burstStep = rateTick & burstMode & ~burstZero;

  always_ff @(posedge CLK) begin
    if (FPGA_RESET) begin
      rateCnt   <= '0;
      runEnable <= 1'b0;
      goMode    <= 1'b0;
      burstMode <= 1'b0;
      eboxSS    <= 1'b0;
      stepPend  <= 1'b0;
      mrReset   <= 1'b0;
    end else begin
      rateCnt   <= rateCnt + 1'b1;
      runEnable <= rateTick & (goMode | (burstMode & ~burstZero) | stepPend);

      if (ctlStrobe) begin
        // Any control function reloads every mode, so others stop the clock
        goMode    <= (ctlCode == clkPkg::start);
        burstMode <= (ctlCode == clkPkg::burst);
        eboxSS    <= (ctlCode == clkPkg::eboxSS);
      end

      if (ctlStrobe && (ctlCode == clkPkg::singleStep)) begin
        stepPend <= 1'b1;
      end else if (rateTick) begin
        stepPend <= 1'b0;  // Step used on this tick
      end

      if (ctlStrobe && (ctlCode == clkPkg::setReset)) begin
        mrReset <= 1'b1;
      end else if (ctlStrobe && (ctlCode == clkPkg::clrReset)) begin
        mrReset <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/clkDiagMux.sv
/*
 * Diagnostic status word select
 * Unused upper bits read as zero
 */
`include "clk_params.svh"

module clkDiagMux (
  input  logic [`CLK_SEL_W-1:0]   wordSel,
  input  logic                    goMode,
  input  logic                    burstMode,
  input  logic                    eboxSS,
  input  logic                    mrReset,
  input  logic [`CLK_BURST_W-1:0] burstCount,
  input  logic [`CLK_RATE_W-1:0]  sourceSel,
  input  logic [`CLK_RATE_W-1:0]  rateSel,
  input  logic [`CLK_DIS_W-1:0]   ebosDis,
  input  logic [`CLK_DATA_W-1:0]  parChk,
  input  logic [`CLK_DATA_W-1:0]  miscEn,
  output logic [`CLK_DIAG_W-1:0]  statusWord
);

  always_comb begin
    statusWord = '0;
    case (wordSel)
      3'd0: statusWord = {goMode, burstMode, burstCount[7:4]};  // Count high nibble
      3'd1: statusWord = {eboxSS, mrReset, burstCount[3:0]};
      3'd2: statusWord = {2'b00, sourceSel, rateSel};
      3'd3: statusWord = {3'b000, ebosDis};
      3'd4: statusWord = {2'b00, parChk};
      3'd5: statusWord = {2'b00, miscEn};
      default: statusWord = '0;  // Words 6 and 7
    endcase
  end

endmodule

// File: verilog/clkBoard.sv
/*
 * Clock board diagnostic top level
 * Host function port, configuration, burst count and EBOX clock gate
 */
`include "clk_params.svh"

module clkBoard (
  input  logic                    CLK,
  input  logic                    FPGA_RESET,
  input  logic                    funcReq,
  input  clkPkg::funcGroup_t      funcGroup,
  input  logic [`CLK_SEL_W-1:0]   funcSel,
  input  logic [`CLK_DATA_W-1:0]  funcData,
  output logic                    funcAck,
  output logic [`CLK_DIAG_W-1:0]  readData,
  output logic                    runEnable,
  output logic                    mrReset
);

  logic                    ctlStrobe;
  clkPkg::ctlFunc_t        ctlCode;
  logic                    ldStrobe;
  clkPkg::ldFunc_t         ldCode;
  logic [`CLK_DATA_W-1:0]  ldData;
  logic [`CLK_SEL_W-1:0]   wordSel;
  logic [`CLK_DIAG_W-1:0]  statusWord;
  logic [`CLK_RATE_W-1:0]  sourceSel;
  logic [`CLK_RATE_W-1:0]  rateSel;
  logic [`CLK_DIS_W-1:0]   ebosDis;
  logic [`CLK_DATA_W-1:0]  parChk;
  logic [`CLK_DATA_W-1:0]  miscEn;
  logic [`CLK_BURST_W-1:0] burstCount;
  logic                    burstZero;
  logic                    burstStep;
  logic                    goMode;
  logic                    burstMode;
  logic                    eboxSS;

  diagFuncPort uPort (
    .CLK, .FPGA_RESET, .funcReq, .funcGroup, .funcSel, .funcData, .statusWord,
    .funcAck, .readData, .ctlStrobe, .ctlCode, .ldStrobe, .ldCode, .ldData, .wordSel
  );

  clkConfigRegs uConfig (
    .CLK, .FPGA_RESET, .ldStrobe, .ldCode, .ldData,
    .sourceSel, .rateSel, .ebosDis, .parChk, .miscEn
  );

  burstCounter uBurst (
    .CLK, .FPGA_RESET, .ldStrobe, .ldCode, .ldData, .burstStep,
    .burstCount, .burstZero
  );

  clockGate uGate (
    .CLK, .FPGA_RESET, .ctlStrobe, .ctlCode, .rateSel, .burstZero,
    .runEnable, .burstStep, .goMode, .burstMode, .eboxSS, .mrReset
  );

  clkDiagMux uDiag (
    .wordSel, .goMode, .burstMode, .eboxSS, .mrReset, .burstCount,
    .sourceSel, .rateSel, .ebosDis, .parChk, .miscEn, .statusWord
  );

endmodule

// File: test/clkBoard_asserts.sv
/*
 * Clock board handshake and clock gate assertions
 */
module clkBoard_asserts (
  input logic CLK,
  input logic FPGA_RESET,
  input logic funcReq,
  input logic funcAck,
  input logic runEnable,
  input logic rateTick
);

  ackNeedsReq: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    $rose(funcAck) |-> $past(funcReq))
    else $error("funcAck rose without funcReq");

  // Ack holds until the host has released req
  ackHoldsForReq: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    $fell(funcAck) |-> !$past(funcReq))
    else $error("funcAck fell while funcReq was high");

  // runEnable is registered, so it trails its tick by one cycle
  runOnTick: assert property (@(posedge CLK) disable iff (FPGA_RESET)
    runEnable |-> $past(rateTick))
    else $error("runEnable high without a rate tick");

endmodule

bind clkBoard clkBoard_asserts uAsserts (
  .CLK, .FPGA_RESET, .funcReq, .funcAck, .runEnable, .rateTick(uGate.rateTick)
);

// File: test/clkChecker.sv
/*
 * Clock board result checker
 * Counts acks and runEnable pulses, compares against the model values
 */
`include "clk_params.svh"

module clkChecker (
  input logic                   CLK,
  input logic                   FPGA_RESET,
  input logic                   funcReq,
  input logic                   funcAck,
  input logic [`CLK_DIAG_W-1:0] readData,
  input logic                   runEnable,
  input logic                   mrReset
);

  int   errCount   = 0;
  int   testErrs   = 0;
  int   testCount  = 0;
  int   checkCount = 0;
  int   pulseCount = 0;
  int   ackCount   = 0;
  logic ackSeen    = 1'b0;

  // Sampled mid-cycle, away from the DUT's edges
  always @(negedge CLK) begin
    if (!FPGA_RESET) begin
      if (runEnable) pulseCount++;
      if (funcAck && !ackSeen) ackCount++;
      if (ackSeen && !funcAck && funcReq) begin
        errCount++;
        testErrs++;
        $display("funcAck dropped while funcReq was still high");
      end
    end
    ackSeen = funcAck;
  end

  task automatic compare(input string name, input int exp, input int act);
    checkCount++;
    if (exp != act) begin
      errCount++;
      testErrs++;
      $display("ERR %s expected 0x%0h got 0x%0h", name, exp, act);
    end
  endtask

  task automatic clearCounts();
    @(posedge CLK);  // Counters only move on the falling edge
    pulseCount = 0;
    ackCount   = 0;
  endtask

  task automatic checkRead(input logic [5:0] exp);
    compare("readData", int'(exp), int'(readData));
  endtask

  task automatic checkPulses(input int exp);
    compare("runEnable pulses", exp, pulseCount);
  endtask

  task automatic checkAcks(input int exp);
    compare("funcAck count", exp, ackCount);
  endtask

  task automatic checkReset(input logic exp);
    compare("mrReset", int'(exp), int'(mrReset));
  endtask

  task automatic checkAtLeast(input int minPulses);
    checkCount++;
    if (pulseCount < minPulses) begin
      errCount++;
      testErrs++;
      $display("ERR runEnable pulses expected at least 0x%0h got 0x%0h", minPulses, pulseCount);
    end
  endtask

  task automatic endTest(input string name);
    testCount++;
    $display("%s: %0d errors", name, testErrs);
    testErrs = 0;
  endtask

  task automatic summary();
    $display("tests %0d checks %0d errors %0d", testCount, checkCount, errCount);
  endtask

endmodule

// File: test/tbClkBoard.sv
/*
 * Clock board testbench
 * Seeded random diagnostic functions checked against a reference model
 */
`include "clk_params.svh"

module tbClkBoard;

  localparam int NumReqs    = 160;
  localparam int LongestReq = 16 + 255 * 8 + 32;  // Handshake plus a full burst at 1 in 8

  logic                    CLK = 1'b0;
  logic                    FPGA_RESET;
  logic                    funcReq;
  clkPkg::funcGroup_t      funcGroup;
  logic [`CLK_SEL_W-1:0]   funcSel;
  logic [`CLK_DATA_W-1:0]  funcData;
  logic                    funcAck;
  logic [`CLK_DIAG_W-1:0]  readData;
  logic                    runEnable;
  logic                    mrReset;
  // Reference model state
  logic [1:0] mSource, mRate;
  logic [2:0] mDis;
  logic [3:0] mPar, mMisc;
  logic [7:0] mCount;
  logic       mGo, mBurst, mEbox, mReset;

  clkBoard dut (.*);
  clkChecker chk (.CLK, .FPGA_RESET, .funcReq, .funcAck, .readData, .runEnable, .mrReset);

  always #2 CLK = ~CLK;

  initial begin
    #(NumReqs * LongestReq * 4);
    $display("Timeout: the run did not finish within the expected time");
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic [5:0] modelWord(input logic [2:0] sel);
    case (sel)
      3'd0: return {mGo, mBurst, mCount[7:4]};
      3'd1: return {mEbox, mReset, mCount[3:0]};
      3'd2: return {2'b00, mSource, mRate};
      3'd3: return {3'b000, mDis};
      3'd4: return {2'b00, mPar};
      3'd5: return {2'b00, mMisc};
      default: return 6'd0;
    endcase
  endfunction

  task automatic applyModel(input clkPkg::funcGroup_t g, input logic [2:0] s,
                            input logic [3:0] d);
    if (g == clkPkg::ctlFunc) begin
      mGo    = (s == clkPkg::start);  // Every control function reloads the modes
      mBurst = (s == clkPkg::burst);
      mEbox  = (s == clkPkg::eboxSS);
      if (s == clkPkg::setReset) begin
        mReset = 1'b1;
      end else if (s == clkPkg::clrReset) begin
        mReset = 1'b0;
      end
    end else if (g == clkPkg::ldFunc) begin
      case (s)
        3'd2: mCount[3:0] = d;
        3'd3: mCount[7:4] = d;
        3'd4: {mSource, mRate} = d;
        3'd5: mDis = d[2:0];
        3'd6: mPar = d;
        3'd7: mMisc = d;
        default: ;
      endcase
    end
  endtask

  // Four-phase request that returns once the ack has dropped
  task automatic request(input clkPkg::funcGroup_t g, input logic [2:0] s,
                         input logic [3:0] d);
    @(posedge CLK);
    funcReq   <= 1'b1;
    funcGroup <= g;
    funcSel   <= s;
    funcData  <= d;
    do @(negedge CLK); while (!funcAck);
    @(posedge CLK);
    funcReq <= 1'b0;
    do @(negedge CLK); while (funcAck);
    applyModel(g, s, d);
  endtask

  task automatic readWord(input logic [2:0] s);
    request(clkPkg::readFunc, s, 4'h0);
    chk.checkRead(modelWord(s));
  endtask

  task automatic waitPulses(input int n, input int limit);
    int waited = 0;
    while (chk.pulseCount < n && waited < limit) begin
      @(posedge CLK);
      waited++;
    end
    repeat (16) @(posedge CLK);  // Room for a stray extra pulse at 1 in 8
  endtask

  initial begin
    clkPkg::funcGroup_t g;
    logic [2:0]         s;
    int                 i;
    int                 n;
    int                 r;
    void'($urandom(32'h9793));
    FPGA_RESET <= 1'b1;
    funcReq    <= 1'b0;
    funcGroup  <= clkPkg::ctlFunc;
    funcSel    <= '0;
    funcData   <= '0;
    {mSource, mRate, mDis, mPar, mMisc, mCount, mGo, mBurst, mEbox, mReset} = '0;
    repeat (4) @(posedge CLK);
    FPGA_RESET <= 1'b0;

    chk.clearCounts();
    for (i = 0; i < 20; i++) begin
      g = clkPkg::funcGroup_t'($urandom_range(2, 0));
      s = 3'($urandom_range(7, 0));
      if (g == clkPkg::ctlFunc && s == clkPkg::burst) begin
        s = clkPkg::none;  // Keep the count still
      end
      if (g == clkPkg::readFunc) begin
        readWord(s);
      end else begin
        request(g, s, 4'($urandom_range(15, 0)));
      end
    end
    chk.checkAcks(20);
    request(clkPkg::ctlFunc, clkPkg::none, 4'h0);
    chk.endTest("handshake");

    for (i = 0; i < 24; i++) begin
      s = 3'($urandom_range(7, 4));
      request(clkPkg::ldFunc, s, 4'($urandom_range(15, 0)));
      readWord(s - 3'd2);  // Load 4..7 lands in word 2..5
    end
    readWord(3'd6);
    readWord(3'd7);
    chk.endTest("loadRead");

    for (i = 0; i < 4; i++) begin
      n = $urandom_range(255, 1);
      request(clkPkg::ctlFunc, clkPkg::none, 4'h0);
      request(clkPkg::ldFunc, clkPkg::rateSel,
              {2'($urandom_range(3, 0)), 2'($urandom_range(3, 0))});
      request(clkPkg::ldFunc, clkPkg::burstLo, n[3:0]);
      request(clkPkg::ldFunc, clkPkg::burstHi, n[7:4]);
      chk.clearCounts();
      request(clkPkg::ctlFunc, clkPkg::burst, 4'h0);
      waitPulses(n, n * 8 + 16);
      mCount = '0;  // Burst drains the count
      chk.checkPulses(n);
      readWord(3'd0);
      readWord(3'd1);
    end
    chk.endTest("burst");

    for (r = 0; r < 4; r++) begin
      request(clkPkg::ldFunc, clkPkg::rateSel, 4'(r));
      chk.clearCounts();
      request(clkPkg::ctlFunc, clkPkg::singleStep, 4'h0);
      waitPulses(1, 16);
      chk.checkPulses(1);
      chk.clearCounts();
      request(clkPkg::ctlFunc, clkPkg::start, 4'h0);
      repeat (40) @(posedge CLK);
      chk.checkAtLeast(40 / (1 << r) - 1);
      s = 3'($urandom_range(2, 0));
      s = (s == 3'd0) ? 3'd0 : s + 3'd2;  // none, eboxSS or condSS
      request(clkPkg::ctlFunc, s, 4'h0);
      chk.clearCounts();
      repeat (16) @(posedge CLK);
      chk.checkPulses(0);
      readWord(3'd1);
    end
    chk.endTest("stepStop");

    for (i = 0; i < 8; i++) begin
      request(clkPkg::ctlFunc, clkPkg::start, 4'h0);
      s = ($urandom_range(1, 0) == 1) ? clkPkg::setReset : clkPkg::clrReset;
      request(clkPkg::ctlFunc, s, 4'h0);
      chk.checkReset(mReset);
      readWord(3'd0);
      readWord(3'd1);
    end
    chk.endTest("resetCtl");

    chk.summary();
    if (chk.errCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+include
verilog/clkPkg.sv
verilog/diagFuncPort.sv
verilog/clkConfigRegs.sv
verilog/burstCounter.sv
verilog/clockGate.sv
verilog/clkDiagMux.sv
verilog/clkBoard.sv
test/clkBoard_asserts.sv
test/clkChecker.sv
test/tbClkBoard.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbClkBoard
SEED      ?= 38803
LOG       ?= sim.log
BUILD     ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f sources.f

run: build
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f sources.f

clean:
	rm -rf $(BUILD) $(LOG)
